/* rtl/ex_pkg.sv */
package ex_pkg;

    // datapath and register file widths
    localparam int XLEN      = 32;
    localparam int REG_AW    = 5;
    localparam int EXCCODE_W = 5;

    // jal link destination
    localparam logic [REG_AW-1:0] LINK_REG = 5'd31;

    // result width of the leading-one count, 0 to XLEN
    localparam int CNT_W = $clog2(XLEN) + 1;

    // major opcodes that carry a funct field
    localparam logic [5:0] OPC_SPECIAL  = 6'h00;
    localparam logic [5:0] OPC_SPECIAL2 = 6'h1c;

    typedef enum logic [EXCCODE_W-1:0] {
        EXC_NONE = 5'd0,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_e;

    typedef enum logic [4:0] {
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA,
        OP_LUI, OP_CLZ, OP_CLO,
        OP_MOVZ, OP_MOVN,
        OP_BEQ, OP_BNE, OP_J, OP_JAL, OP_JR,
        OP_NONE,
        OP_RI
    } op_e;

    // decode to execute
    typedef struct packed {
        op_e               op;
        logic              use_imm;
        logic              use_sa;
        // shift amount lands here too for sll/srl/sra
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   pc;
        logic [25:0]       jidx;
        logic [XLEN-1:0]   rs;
        logic [XLEN-1:0]   rt;
    } dec_t;

    // execute to result
    typedef struct packed {
        op_e               op;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   value;
        logic              ovf;
        logic              move_ok;
        logic              taken;
        logic [XLEN-1:0]   target;
    } exe_t;

endpackage

/* rtl/ex_decode.sv */
module ex_decode import ex_pkg::*; (
    input  logic            clk,
    input  logic            resetn,

    input  logic            valid_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] inst_i,
    input  logic [XLEN-1:0] rs_data_i,
    input  logic [XLEN-1:0] rt_data_i,

    output logic            dec_valid_o,
    output dec_t            dec_o
);

    logic [5:0]        opcode;
    logic [5:0]        funct;
    logic [REG_AW-1:0] rt_idx;
    logic [REG_AW-1:0] rd_idx;
    logic [XLEN-1:0]   imm_sx;
    logic [XLEN-1:0]   imm_zx;
    logic [XLEN-1:0]   sa_ext;
    dec_t              dec_d;

    assign opcode = inst_i[31:26];
    assign funct  = inst_i[5:0];
    assign rt_idx = inst_i[20:16];
    assign rd_idx = inst_i[15:11];

    assign imm_sx = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_zx = {16'd0, inst_i[15:0]};
    assign sa_ext = {{(XLEN-5){1'b0}}, inst_i[10:6]};

    always_comb begin
        dec_d.op      = OP_RI;
        dec_d.use_imm = 1'b0;
        dec_d.use_sa  = 1'b0;
        dec_d.imm     = imm_sx;
        dec_d.waddr   = '0;
        dec_d.pc      = pc_i;
        dec_d.jidx    = inst_i[25:0];
        dec_d.rs      = rs_data_i;
        dec_d.rt      = rt_data_i;

        if (inst_i == '0) begin
            dec_d.op = OP_NONE;
        end else begin
            case (opcode)
                OPC_SPECIAL: begin
                    dec_d.waddr = rd_idx;
                    case (funct)
                        6'h00: begin
                            dec_d.op     = OP_SLL;
                            dec_d.use_sa = 1'b1;
                            dec_d.imm    = sa_ext;
                        end
                        6'h02: begin
                            dec_d.op     = OP_SRL;
                            dec_d.use_sa = 1'b1;
                            dec_d.imm    = sa_ext;
                        end
                        6'h03: begin
                            dec_d.op     = OP_SRA;
                            dec_d.use_sa = 1'b1;
                            dec_d.imm    = sa_ext;
                        end
                        // variable shifts take the amount from rs
                        6'h04: dec_d.op = OP_SLL;
                        6'h06: dec_d.op = OP_SRL;
                        6'h07: dec_d.op = OP_SRA;
                        6'h08: begin
                            dec_d.op    = OP_JR;
                            dec_d.waddr = '0;
                        end
                        6'h0a: dec_d.op = OP_MOVZ;
                        6'h0b: dec_d.op = OP_MOVN;
                        6'h20: dec_d.op = OP_ADD;
                        6'h21: dec_d.op = OP_ADDU;
                        6'h22: dec_d.op = OP_SUB;
                        6'h23: dec_d.op = OP_SUBU;
                        6'h24: dec_d.op = OP_AND;
                        6'h25: dec_d.op = OP_OR;
                        6'h26: dec_d.op = OP_XOR;
                        6'h27: dec_d.op = OP_NOR;
                        6'h2a: dec_d.op = OP_SLT;
                        6'h2b: dec_d.op = OP_SLTU;
                        default: dec_d.waddr = '0;
                    endcase
                end
                OPC_SPECIAL2: begin
                    dec_d.waddr = rd_idx;
                    case (funct)
                        6'h20: dec_d.op = OP_CLZ;
                        6'h21: dec_d.op = OP_CLO;
                        default: dec_d.waddr = '0;
                    endcase
                end
                6'h02: dec_d.op = OP_J;
                6'h03: begin
                    dec_d.op    = OP_JAL;
                    dec_d.waddr = LINK_REG;
                end
                6'h04: dec_d.op = OP_BEQ;
                6'h05: dec_d.op = OP_BNE;
                default: begin
                    // immediate forms reuse the register op, result to rt
                    dec_d.use_imm = 1'b1;
                    dec_d.waddr   = rt_idx;
                    case (opcode)
                        6'h08: dec_d.op = OP_ADD;
                        6'h09: dec_d.op = OP_ADDU;
                        6'h0a: dec_d.op = OP_SLT;
                        6'h0b: dec_d.op = OP_SLTU;
                        6'h0c: begin
                            dec_d.op  = OP_AND;
                            dec_d.imm = imm_zx;
                        end
                        6'h0d: begin
                            dec_d.op  = OP_OR;
                            dec_d.imm = imm_zx;
                        end
                        6'h0e: begin
                            dec_d.op  = OP_XOR;
                            dec_d.imm = imm_zx;
                        end
                        6'h0f: dec_d.op = OP_LUI;
                        default: begin
                            dec_d.use_imm = 1'b0;
                            dec_d.waddr   = '0;
                        end
                    endcase
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            dec_o <= dec_d;
        end
    end

endmodule

/* rtl/ex_execute.sv */
module ex_execute import ex_pkg::*; (
    input  logic clk,
    input  logic resetn,

    input  logic dec_valid_i,
    input  dec_t dec_i,

    output logic exe_valid_o,
    output exe_t exe_o
);

    logic [XLEN-1:0]  opa;
    logic [XLEN-1:0]  opb;
    logic [XLEN-1:0]  sum;
    logic [XLEN-1:0]  diff;
    logic             add_ovf;
    logic             sub_ovf;
    logic [XLEN-1:0]  pc4;
    logic [XLEN-1:0]  br_target;
    logic [XLEN-1:0]  j_target;
    logic [CNT_W-1:0] lead_cnt;
    logic             slt;
    logic             sltu;
    exe_t             exe_d;

    // priority count of leading ones, XLEN when all bits set
    function automatic logic [CNT_W-1:0] lead_ones(input logic [XLEN-1:0] x);
        logic [CNT_W-1:0] cnt;
        logic             run;
        cnt = '0;
        run = 1'b1;
        for (int i = XLEN - 1; i >= 0; i--) begin
            run = run & x[i];
            cnt = cnt + {{(CNT_W-1){1'b0}}, run};
        end
        return cnt;
    endfunction

    assign opa = dec_i.use_sa  ? dec_i.imm : dec_i.rs;
    assign opb = dec_i.use_imm ? dec_i.imm : dec_i.rt;

    assign sum  = opa + opb;
    assign diff = opa - opb;

    // signed overflow on matching or opposing operand signs
    assign add_ovf = (opa[XLEN-1] == opb[XLEN-1]) && (sum[XLEN-1] != opa[XLEN-1]);
    assign sub_ovf = (opa[XLEN-1] != opb[XLEN-1]) && (diff[XLEN-1] != opa[XLEN-1]);

    assign slt  = $signed(opa) < $signed(opb);
    assign sltu = opa < opb;

    assign lead_cnt = (dec_i.op == OP_CLO) ? lead_ones(dec_i.rs) : lead_ones(~dec_i.rs);

    assign pc4       = dec_i.pc + 32'd4;
    assign br_target = pc4 + {dec_i.imm[XLEN-3:0], 2'b00};
    assign j_target  = {pc4[XLEN-1:28], dec_i.jidx, 2'b00};

    always_comb begin
        exe_d.op      = dec_i.op;
        exe_d.waddr   = dec_i.waddr;
        exe_d.value   = '0;
        exe_d.ovf     = 1'b0;
        exe_d.move_ok = 1'b1;
        exe_d.taken   = 1'b0;
        exe_d.target  = br_target;

        case (dec_i.op)
            OP_ADD: begin
                exe_d.value = sum;
                exe_d.ovf   = add_ovf;
            end
            OP_SUB: begin
                exe_d.value = diff;
                exe_d.ovf   = sub_ovf;
            end
            OP_ADDU: exe_d.value = sum;
            OP_SUBU: exe_d.value = diff;
            OP_AND:  exe_d.value = opa & opb;
            OP_OR:   exe_d.value = opa | opb;
            OP_XOR:  exe_d.value = opa ^ opb;
            OP_NOR:  exe_d.value = ~(opa | opb);
            OP_SLT:  exe_d.value = {{(XLEN-1){1'b0}}, slt};
            OP_SLTU: exe_d.value = {{(XLEN-1){1'b0}}, sltu};
            // shifted value is rt, amount from sa or rs
            OP_SLL:  exe_d.value = opb << opa[4:0];
            OP_SRL:  exe_d.value = opb >> opa[4:0];
            OP_SRA:  exe_d.value = $signed(opb) >>> opa[4:0];
            OP_LUI:  exe_d.value = {dec_i.imm[15:0], 16'd0};
            OP_CLZ, OP_CLO: exe_d.value = {{(XLEN-CNT_W){1'b0}}, lead_cnt};
            OP_MOVZ: begin
                exe_d.value   = dec_i.rs;
                exe_d.move_ok = (dec_i.rt == '0);
            end
            OP_MOVN: begin
                exe_d.value   = dec_i.rs;
                exe_d.move_ok = (dec_i.rt != '0);
            end
            OP_BEQ: exe_d.taken = (dec_i.rs == dec_i.rt);
            OP_BNE: exe_d.taken = (dec_i.rs != dec_i.rt);
            OP_J: begin
                exe_d.taken  = 1'b1;
                exe_d.target = j_target;
            end
            OP_JAL: begin
                exe_d.value  = dec_i.pc + 32'd8;
                exe_d.taken  = 1'b1;
                exe_d.target = j_target;
            end
            OP_JR: begin
                exe_d.taken  = 1'b1;
                exe_d.target = dec_i.rs;
            end
            default: exe_d.value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exe_valid_o <= 1'b0;
        end else begin
            exe_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            exe_o <= exe_d;
        end
    end

endmodule

/* rtl/ex_result.sv */
module ex_result import ex_pkg::*; (
    input  logic              clk,
    input  logic              resetn,

    input  logic              exe_valid_i,
    input  exe_t              exe_i,

    output logic              valid_o,
    output logic              wen_o,
    output logic [REG_AW-1:0] waddr_o,
    output logic [XLEN-1:0]   wdata_o,
    output logic              branch_o,
    output logic [XLEN-1:0]   target_o,
    output logic              exc_o,
    output exc_e              exccode_o
);

    logic is_ri;
    logic is_exc;
    logic wen;
    exc_e code;

    assign is_ri  = (exe_i.op == OP_RI);
    assign is_exc = is_ri || exe_i.ovf;

    // reserved instruction wins over overflow
    always_comb begin
        if (is_ri) begin
            code = EXC_RI;
        end else if (exe_i.ovf) begin
            code = EXC_OV;
        end else begin
            code = EXC_NONE;
        end
    end

    // no write on exception, failed move or r0
    assign wen = !is_exc && exe_i.move_ok && (exe_i.waddr != '0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_o   <= 1'b0;
            wen_o     <= 1'b0;
            branch_o  <= 1'b0;
            exc_o     <= 1'b0;
            exccode_o <= EXC_NONE;
        end else begin
            valid_o   <= exe_valid_i;
            wen_o     <= exe_valid_i && wen;
            branch_o  <= exe_valid_i && exe_i.taken;
            exc_o     <= exe_valid_i && is_exc;
            exccode_o <= exe_valid_i ? code : EXC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid_i) begin
            waddr_o  <= exe_i.waddr;
            wdata_o  <= exe_i.value;
            target_o <= exe_i.target;
        end
    end

endmodule

/* rtl/ex_stage.sv */
module ex_stage import ex_pkg::*; (
    input  logic              clk,
    input  logic              resetn,

    input  logic              valid_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic [XLEN-1:0]   inst_i,
    input  logic [XLEN-1:0]   rs_data_i,
    input  logic [XLEN-1:0]   rt_data_i,

    output logic              valid_o,
    output logic              wen_o,
    output logic [REG_AW-1:0] waddr_o,
    output logic [XLEN-1:0]   wdata_o,
    output logic              branch_o,
    output logic [XLEN-1:0]   target_o,
    output logic              exc_o,
    output exc_e              exccode_o
);

    logic dec_valid;
    dec_t dec;
    logic exe_valid;
    exe_t exe;

    ex_decode i_ex_decode (
        .clk         (clk),
        .resetn      (resetn),
        .valid_i     (valid_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .rs_data_i   (rs_data_i),
        .rt_data_i   (rt_data_i),
        .dec_valid_o (dec_valid),
        .dec_o       (dec)
    );

    ex_execute i_ex_execute (
        .clk         (clk),
        .resetn      (resetn),
        .dec_valid_i (dec_valid),
        .dec_i       (dec),
        .exe_valid_o (exe_valid),
        .exe_o       (exe)
    );

    ex_result i_ex_result (
        .clk         (clk),
        .resetn      (resetn),
        .exe_valid_i (exe_valid),
        .exe_i       (exe),
        .valid_o     (valid_o),
        .wen_o       (wen_o),
        .waddr_o     (waddr_o),
        .wdata_o     (wdata_o),
        .branch_o    (branch_o),
        .target_o    (target_o),
        .exc_o       (exc_o),
        .exccode_o   (exccode_o)
    );

endmodule

/* test/ex_stage_assertions.sv */
module ex_stage_assertions import ex_pkg::*; (
    input logic clk,
    input logic resetn,
    input logic valid_i,
    input logic valid_o,
    input logic wen_o,
    input logic branch_o,
    input logic exc_o,
    input exc_e exccode_o
);

    // fixed three-edge latency, both directions
    a_latency: assert property (@(posedge clk) disable iff (!resetn)
        valid_i |-> ##3 valid_o) else $error("valid_o missing three cycles after valid_i");
    a_no_extra: assert property (@(posedge clk) disable iff (!resetn)
        valid_o |-> $past(valid_i, 3)) else $error("valid_o without matching valid_i");

    a_wen_valid: assert property (@(posedge clk) disable iff (!resetn)
        wen_o |-> valid_o) else $error("wen_o high while valid_o low");
    a_branch_valid: assert property (@(posedge clk) disable iff (!resetn)
        branch_o |-> valid_o) else $error("branch_o high while valid_o low");
    a_exc_valid: assert property (@(posedge clk) disable iff (!resetn)
        exc_o |-> valid_o) else $error("exc_o high while valid_o low");
    a_exc_no_wen: assert property (@(posedge clk) disable iff (!resetn)
        exc_o |-> !wen_o) else $error("write enabled together with an exception");

    // outputs cleared by reset
    a_quiet: assert property (@(posedge clk) $rose(resetn) |->
        !valid_o && !wen_o && !branch_o && !exc_o && exccode_o == EXC_NONE)
        else $error("outputs not quiet after reset");

endmodule

bind ex_stage ex_stage_assertions i_ex_stage_assertions (.*);

/* test/ex_stage_tb.sv */
module ex_stage_tb import ex_pkg::*; ();

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] rs;
        logic [31:0] rt;
        logic        wen;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic        branch;
        logic [31:0] target;
        logic        exc;
        logic [4:0]  code;
    } entry_t;

    localparam logic [31:0] PC_BASE = 32'hbfc0_0000;

    logic clk = 1'b0;
    logic resetn;
    logic valid_i;
    logic [31:0] pc_i;
    logic [31:0] inst_i;
    logic [31:0] rs_data_i;
    logic [31:0] rt_data_i;
    logic valid_o;
    logic wen_o;
    logic [4:0] waddr_o;
    logic [31:0] wdata_o;
    logic branch_o;
    logic [31:0] target_o;
    logic exc_o;
    exc_e exccode_o;

    entry_t tbl[$];
    entry_t exp_q[$];
    int due_q[$];
    int idx_q[$];
    entry_t cur;
    int cycle = 0;
    int mism;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int other_errs = 0;
    logic [15:0] lfsr = 16'd17645;

    ex_stage i_ex_stage (.*);

    always #50 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            // galois step, taps x^16 + x^14 + x^13 + x^11 + 1
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rd,
                                          input logic [4:0] sa);
        return {6'h00, 5'd1, 5'd2, rd, sa, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] opc, input logic [4:0] rt,
                                          input logic [15:0] imm);
        return {opc, 5'd1, rt, imm};
    endfunction

    function automatic logic [31:0] pc_at();
        return PC_BASE + 32'(4 * tbl.size());
    endfunction

    task automatic add_row(input logic [31:0] inst, input logic [31:0] rs, input logic [31:0] rt,
                           input logic wen, input logic [4:0] waddr, input logic [31:0] wdata,
                           input logic branch, input logic [31:0] target, input logic exc,
                           input logic [4:0] code);
        tbl.push_back('{pc_at(), inst, rs, rt, wen, waddr, wdata, branch, target, exc, code});
    endtask

    task automatic expect_write(input logic [31:0] inst, input logic [31:0] rs,
                                input logic [31:0] rt, input logic [4:0] waddr,
                                input logic [31:0] wdata);
        add_row(inst, rs, rt, 1'b1, waddr, wdata, 1'b0, '0, 1'b0, EXC_NONE);
    endtask

    task automatic expect_quiet(input logic [31:0] inst, input logic [31:0] rs,
                                input logic [31:0] rt);
        add_row(inst, rs, rt, 1'b0, '0, '0, 1'b0, '0, 1'b0, EXC_NONE);
    endtask

    task automatic expect_exc(input logic [31:0] inst, input logic [31:0] rs,
                              input logic [31:0] rt, input logic [4:0] code);
        add_row(inst, rs, rt, 1'b0, '0, '0, 1'b0, '0, 1'b1, code);
    endtask

    task automatic expect_branch(input logic [31:0] inst, input logic [31:0] rs,
                                 input logic [31:0] rt, input logic taken,
                                 input logic [31:0] target);
        add_row(inst, rs, rt, 1'b0, '0, '0, taken, target, 1'b0, EXC_NONE);
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc4;
        expect_write(enc_r(6'h20, 3, 0), 5, 7, 3, 12);
        a = rand_word();
        b = rand_word();
        expect_write(enc_r(6'h21, 4, 0), a, b, 4, a + b);
        expect_write(enc_r(6'h22, 5, 0), 10, 3, 5, 7);
        expect_write(enc_r(6'h23, 6, 0), 3, 10, 6, 32'hffff_fff9);
        expect_write(enc_r(6'h24, 7, 0), 32'hf0f0_ff00, 32'h0ff0_f0f0, 7, 32'h00f0_f000);
        expect_write(enc_r(6'h25, 8, 0), 32'hf0f0_ff00, 32'h0ff0_f0f0, 8, 32'hfff0_fff0);
        expect_write(enc_r(6'h27, 10, 0), 32'hf0f0_ff00, 32'h0ff0_f0f0, 10, 32'h000f_000f);
        a = rand_word();
        b = rand_word();
        expect_write(enc_r(6'h26, 9, 0), a, b, 9, a ^ b);
        expect_write(enc_r(6'h2a, 11, 0), -1, 1, 11, 1);
        expect_write(enc_r(6'h2b, 12, 0), -1, 1, 12, 0);
        expect_write(enc_r(6'h00, 13, 4), 0, 32'h8000_0011, 13, 32'h0000_0110);
        expect_write(enc_r(6'h02, 14, 8), 0, 32'h8000_0000, 14, 32'h0080_0000);
        expect_write(enc_r(6'h03, 15, 8), 0, 32'h8000_0000, 15, 32'hff80_0000);
        expect_write(enc_r(6'h07, 17, 0), 4, 32'hf000_0000, 17, 32'hff00_0000);
        expect_write(enc_i(6'h08, 18, 16'hfffe), 5, 0, 18, 3);
        expect_write(enc_i(6'h0a, 20, 16'h0005), -3, 0, 20, 1);
        expect_write(enc_i(6'h0c, 22, 16'hff0f), -1, 0, 22, 32'h0000_ff0f);
        expect_write(enc_i(6'h0d, 23, 16'h8001), 32'h0001_0000, 0, 23, 32'h0001_8001);
        expect_write(enc_i(6'h0e, 24, 16'hffff), 32'hffff_0000, 0, 24, 32'hffff_ffff);
        expect_write(enc_i(6'h0f, 25, 16'habcd), 0, 0, 25, 32'habcd_0000);
        // signed overflow and reserved encodings
        expect_exc(enc_r(6'h20, 3, 0), 32'h7fff_ffff, 1, EXC_OV);
        expect_write(enc_r(6'h21, 3, 0), 32'h7fff_ffff, 1, 3, 32'h8000_0000);
        expect_exc(enc_i(6'h08, 4, 16'h0001), 32'h7fff_ffff, 0, EXC_OV);
        expect_exc(enc_r(6'h22, 5, 0), 32'h8000_0000, 1, EXC_OV);
        expect_exc(enc_i(6'h3f, 3, 0), 0, 0, EXC_RI);
        expect_exc(enc_r(6'h3f, 3, 0), 0, 0, EXC_RI);
        expect_write({6'h1c, 5'd1, 5'd0, 5'd6, 5'd0, 6'h20}, 0, 0, 6, 32);
        expect_write({6'h1c, 5'd1, 5'd0, 5'd6, 5'd0, 6'h20}, -1, 0, 6, 0);
        expect_write({6'h1c, 5'd1, 5'd0, 5'd6, 5'd0, 6'h20}, 32'h0001_0000, 0, 6, 15);
        expect_write({6'h1c, 5'd1, 5'd0, 5'd6, 5'd0, 6'h21}, -1, 0, 6, 32);
        expect_write({6'h1c, 5'd1, 5'd0, 5'd6, 5'd0, 6'h21}, 32'hfff0_0000, 0, 6, 12);
        expect_write(enc_r(6'h0a, 7, 0), 32'h1111, 0, 7, 32'h1111);
        expect_quiet(enc_r(6'h0a, 7, 0), 32'h1111, 5);
        expect_write(enc_r(6'h0b, 8, 0), 32'h2222, 5, 8, 32'h2222);
        expect_quiet(enc_r(6'h0b, 8, 0), 32'h2222, 0);
        expect_quiet(enc_r(6'h21, 0, 0), 1, 2);
        expect_branch(enc_i(6'h04, 2, 16'h0010), 9, 9, 1'b1, pc_at() + 4 + 32'h40);
        expect_branch(enc_i(6'h04, 2, 16'h0010), 9, 8, 1'b0, '0);
        expect_branch(enc_i(6'h05, 2, 16'hfffc), 9, 8, 1'b1, pc_at() + 4 - 16);
        pc4 = pc_at() + 4;
        expect_branch({6'h02, 26'h012_3456}, 0, 0, 1'b1, {pc4[31:28], 26'h012_3456, 2'b00});
        pc4 = pc_at() + 4;
        add_row({6'h03, 26'h100}, 0, 0, 1'b1, 31, pc4 + 4, 1'b1, {pc4[31:28], 26'h100, 2'b00},
                1'b0, EXC_NONE);
        expect_branch(enc_r(6'h08, 0, 0), 32'h0040_2000, 0, 1'b1, 32'h0040_2000);
        expect_quiet(32'h0, 0, 0);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            mism++;
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (resetn && valid_o) begin
            if (exp_q.size() == 0) begin
                $display("valid_o at %0t with no instruction pending", $time);
                other_errs++;
            end else begin
                mism = 0;
                cur = exp_q.pop_front();
                if (due_q[0] != cycle) begin
                    $display("entry %0d: valid_o at cycle %0d, expected at cycle %0d",
                             idx_q[0], cycle, due_q[0]);
                    mism++;
                end
                check_value("wen_o", wen_o, cur.wen);
                check_value("branch_o", branch_o, cur.branch);
                check_value("exc_o", exc_o, cur.exc);
                check_value("exccode_o", exccode_o, cur.code);
                if (cur.wen) begin
                    check_value("waddr_o", waddr_o, cur.waddr);
                    check_value("wdata_o", wdata_o, cur.wdata);
                end
                if (cur.branch) begin
                    check_value("target_o", target_o, cur.target);
                end
                if (mism == 0) begin
                    pass_cnt++;
                    $display("entry %0d ok", idx_q[0]);
                end else begin
                    fail_cnt++;
                    $display("entry %0d failed with %0d errors", idx_q[0], mism);
                end
                void'(due_q.pop_front());
                void'(idx_q.pop_front());
            end
        end else if (resetn && exp_q.size() > 0 && due_q[0] <= cycle) begin
            $display("entry %0d: no valid_o by cycle %0d", idx_q[0], cycle);
            fail_cnt++;
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
            void'(idx_q.pop_front());
        end
    end

    initial begin
        resetn = 1'b0;
        valid_i = 1'b0;
        pc_i = '0;
        inst_i = '0;
        rs_data_i = '0;
        rt_data_i = '0;
        build_table();
        repeat (4) @(posedge clk);
        #10;
        resetn = 1'b1;
        for (int i = 0; i < tbl.size(); i++) begin
            valid_i = 1'b1;
            pc_i = tbl[i].pc;
            inst_i = tbl[i].inst;
            rs_data_i = tbl[i].rs;
            rt_data_i = tbl[i].rt;
            exp_q.push_back(tbl[i]);
            due_q.push_back(cycle + 3);
            idx_q.push_back(i);
            @(posedge clk);
            #10;
        end
        valid_i = 1'b0;
        wait (exp_q.size() == 0);
        repeat (3) @(posedge clk);
        $display("%0d entries passed, %0d failed, %0d other errors",
                 pass_cnt, fail_cnt, other_errs);
        if (fail_cnt == 0 && other_errs == 0 && pass_cnt == tbl.size()) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #1;
        #((tbl.size() + 10) * 100);
        $display("timeout, the run did not complete in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* compile.f */
rtl/ex_pkg.sv
rtl/ex_decode.sv
rtl/ex_execute.sv
rtl/ex_result.sv
rtl/ex_stage.sv
test/ex_stage_assertions.sv
test/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - rtl/ex_pkg.sv
  - rtl/ex_decode.sv
  - rtl/ex_execute.sv
  - rtl/ex_result.sv
  - rtl/ex_stage.sv
  - target: test
    files:
      - test/ex_stage_assertions.sv
      - test/ex_stage_tb.sv
